/* Makefile */
TOOL     = verilator
TOP      = tb_seq_top
FILELIST = compile.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+tb
design/seq_pkg.sv
design/seq_decode.sv
design/seq_stack.sv
design/seq_counter.sv
design/seq_top.sv
tb/tb_seq_top.sv

/* design/seq_counter.sv */
module seq_counter (
    input  logic           clk,
    input  logic           reset,
    input  seq_pkg::addr_t d,
    input  logic           load,        // decoded load, LDCT or PUSH on pass
    input  logic           decrement,
    input  logic           rld_n,       // external forced load, active low
    output seq_pkg::addr_t count,
    output logic           count_zero
);

    logic do_load;

    assign do_load    = load | ~rld_n;   // either source loads
    assign count_zero = (count == '0);

    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (do_load)
            count <= d;
        else if (decrement)
            count <= count - 1'b1;   // loops end when this reaches zero
    end

    // a zero count without a load must not wrap around
    a_no_wrap: assert property (@(posedge clk) disable iff (reset)
        (count_zero && !do_load) |=> count_zero);

endmodule

/* design/seq_decode.sv */
module seq_decode (
    input  seq_pkg::seq_op_e   op,
    input  logic               cc_n,        // condition, active low
    input  logic               ccen_n,      // condition enable, active low
    input  logic               count_zero,  // from the register/counter
    output seq_pkg::seq_ctrl_t ctrl,
    output logic               pl_n,
    output logic               map_n,
    output logic               vect_n
);
    import seq_pkg::*;

    logic fail;   // condition test failed

    // with ccen_n high the test always passes
    assign fail = cc_n & ~ccen_n;

    always_comb begin
        ctrl       = '0;
        ctrl.y_src = Y_UPC;   // most fail paths just continue
        unique case (op)
            JZ: begin
                ctrl.y_src = Y_ZERO;
                ctrl.clear = 1'b1;   // stack and upc both go back to zero
            end
            CJS: begin
                if (!fail) begin
                    ctrl.y_src = Y_DIRECT;
                    ctrl.push  = 1'b1;   // save return address
                end
            end
            JMAP: begin
                ctrl.y_src = Y_DIRECT;   // unconditional, map prom drives d
            end
            CJP: begin
                if (!fail)
                    ctrl.y_src = Y_DIRECT;
            end
            PUSH: begin
                ctrl.push       = 1'b1;
                ctrl.load_count = ~fail;   // counter loads only on pass
            end
            JSRP: begin
                ctrl.y_src = fail ? Y_COUNT : Y_DIRECT;
                ctrl.push  = 1'b1;         // pushes either way
            end
            CJV: begin
                if (!fail)
                    ctrl.y_src = Y_DIRECT;   // vector source
            end
            JRP: begin
                ctrl.y_src = fail ? Y_COUNT : Y_DIRECT;
            end
            RFCT: begin
                if (!count_zero) begin
                    ctrl.y_src     = Y_STACK;   // back to loop start
                    ctrl.decrement = 1'b1;
                end else begin
                    ctrl.pop = 1'b1;            // fall out, drop loop address
                end
            end
            RPCT: begin
                if (!count_zero) begin
                    ctrl.y_src     = Y_DIRECT;
                    ctrl.decrement = 1'b1;
                end
            end
            CRTN: begin
                if (!fail) begin
                    ctrl.y_src = Y_STACK;   // return
                    ctrl.pop   = 1'b1;
                end
            end
            CJPP: begin
                if (!fail) begin
                    ctrl.y_src = Y_DIRECT;
                    ctrl.pop   = 1'b1;
                end
            end
            LDCT: begin
                ctrl.load_count = 1'b1;
            end
            LOOP: begin
                if (!fail)
                    ctrl.pop = 1'b1;        // loop done, continue
                else
                    ctrl.y_src = Y_STACK;   // go around again
            end
            CONT: begin
                ctrl.y_src = Y_UPC;
            end
            TWB: begin
                if (!fail) begin
                    ctrl.pop = 1'b1;   // exit 1: condition met, continue
                end else if (!count_zero) begin
                    ctrl.y_src     = Y_STACK;   // exit 2: keep looping
                    ctrl.decrement = 1'b1;
                end else begin
                    ctrl.y_src = Y_DIRECT;      // exit 3: count ran out
                    ctrl.pop   = 1'b1;
                end
            end
        endcase
    end

    // branch source strobes, pipeline is the default source
    assign pl_n   = (op == JMAP) || (op == CJV);
    assign map_n  = (op != JMAP);
    assign vect_n = (op != CJV);

endmodule

/* design/seq_pkg.sv */
package seq_pkg;

    // widths and depths shared by the whole sequencer
    localparam int ADDR_W      = 12;     // microprogram address, direct input, counter
    localparam int STACK_DEPTH = 5;      // usable stack entries, entry 0 is the empty slot
    localparam int SP_W        = 3;      // holds 0..STACK_DEPTH

    typedef logic [ADDR_W-1:0] addr_t;   // address or count value

    // the sixteen Am2910 instructions, encoding is the 4-bit opcode itself
    typedef enum logic [3:0] {
        JZ   = 4'd0,    // jump zero, reset stack
        CJS  = 4'd1,    // cond jump to subroutine via pipeline
        JMAP = 4'd2,    // jump to map address
        CJP  = 4'd3,    // cond jump via pipeline
        PUSH = 4'd4,    // push, cond load counter
        JSRP = 4'd5,    // cond jsb via counter or pipeline
        CJV  = 4'd6,    // cond jump to vector
        JRP  = 4'd7,    // cond jump via counter or pipeline
        RFCT = 4'd8,    // repeat loop while counter nonzero
        RPCT = 4'd9,    // repeat pipeline while counter nonzero
        CRTN = 4'd10,   // cond return
        CJPP = 4'd11,   // cond jump pipeline and pop
        LDCT = 4'd12,   // load counter and continue
        LOOP = 4'd13,   // test end of loop
        CONT = 4'd14,   // continue
        TWB  = 4'd15    // three way branch
    } seq_op_e;

    // where the next address comes from
    typedef enum logic [2:0] {
        Y_ZERO   = 3'd0,
        Y_DIRECT = 3'd1,   // d input, pipeline / map / vector source
        Y_UPC    = 3'd2,   // microprogram counter
        Y_STACK  = 3'd3,   // top of stack
        Y_COUNT  = 3'd4    // register/counter
    } y_src_e;

    // decoded control for one cycle
    typedef struct packed {
        y_src_e y_src;       // next address select
        logic   push;        // push upc onto the stack
        logic   pop;         // drop the top of stack
        logic   clear;       // empty the stack, zero upc
        logic   load_count;  // counter takes d
        logic   decrement;   // counter counts down
    } seq_ctrl_t;

endpackage

/* design/seq_stack.sv */
module seq_stack (
    input  logic           clk,
    input  logic           reset,
    input  logic           push,
    input  logic           pop,
    input  logic           clear,
    input  seq_pkg::addr_t wdata,   // return address, upc before the edge
    output seq_pkg::addr_t top,
    output logic           full
);
    import seq_pkg::*;

    addr_t           mem [1:STACK_DEPTH];   // entry 0 is implied, always zero
    logic [SP_W-1:0] sp;                    // points at the current top
    logic [SP_W-1:0] wr_ptr;

    assign full   = (sp == SP_W'(STACK_DEPTH));
    assign wr_ptr = full ? sp : sp + 1'b1;    // overwrite top when full
    assign top    = (sp == '0) ? '0 : mem[sp];

    always_ff @(posedge clk) begin
        if (reset) begin
            sp <= '0;
            for (int i = 1; i <= STACK_DEPTH; i++)
                mem[i] <= '0;
        end else begin
            if (clear)
                sp <= '0;
            else if (pop) begin
                if (sp != '0)
                    sp <= sp - 1'b1;   // pop on empty stays at zero
            end else if (push && !full)
                sp <= sp + 1'b1;

            if (push)
                mem[wr_ptr] <= wdata;
        end
    end

    // pointer stays inside the stack
    a_sp_range: assert property (@(posedge clk) disable iff (reset)
        sp <= SP_W'(STACK_DEPTH));

    // push into a full stack only replaces the top
    a_full_hold: assert property (@(posedge clk) disable iff (reset)
        (push && full && !pop && !clear) |=> $stable(sp));

    // only the top entry or the one above it can be written
    for (genvar i = 1; i <= STACK_DEPTH; i++) begin : g_hold
        a_entry_hold: assert property (@(posedge clk) disable iff (reset)
            (!push || (sp != SP_W'(i - 1) && sp != SP_W'(i))) |=> $stable(mem[i]));
    end

endmodule

/* design/seq_top.sv */
module seq_top (
    input  logic             clk,
    input  logic             reset,
    input  seq_pkg::seq_op_e op,       // 4-bit instruction
    input  logic             cc_n,
    input  logic             ccen_n,
    input  logic             rld_n,
    input  logic             ci,       // incrementer carry-in
    input  seq_pkg::addr_t   d,        // direct input
    output seq_pkg::addr_t   y,        // next microprogram address
    output logic             pl_n,
    output logic             map_n,
    output logic             vect_n,
    output logic             full
);
    import seq_pkg::*;

    seq_ctrl_t ctrl;
    addr_t     upc;          // microprogram counter register
    addr_t     upc_next;
    addr_t     stack_top;
    addr_t     count;
    logic      count_zero;

    seq_decode u_decode (
        .op         (op),
        .cc_n       (cc_n),
        .ccen_n     (ccen_n),
        .count_zero (count_zero),
        .ctrl       (ctrl),
        .pl_n       (pl_n),
        .map_n      (map_n),
        .vect_n     (vect_n)
    );

    seq_stack u_stack (
        .clk   (clk),
        .reset (reset),
        .push  (ctrl.push),
        .pop   (ctrl.pop),
        .clear (ctrl.clear),
        .wdata (upc),          // return address is the current upc
        .top   (stack_top),
        .full  (full)
    );

    seq_counter u_counter (
        .clk        (clk),
        .reset      (reset),
        .d          (d),
        .load       (ctrl.load_count),
        .decrement  (ctrl.decrement),
        .rld_n      (rld_n),
        .count      (count),
        .count_zero (count_zero)
    );

    // next address mux
    always_comb begin
        unique case (ctrl.y_src)
            Y_ZERO:   y = '0;
            Y_DIRECT: y = d;
            Y_UPC:    y = upc;
            Y_STACK:  y = stack_top;
            Y_COUNT:  y = count;
            default:  y = '0;   // unused encodings
        endcase
    end

    // incrementer, ci low holds the address for a wait loop
    assign upc_next = ctrl.clear ? '0 : y + addr_t'(ci);

    always_ff @(posedge clk) begin
        if (reset)
            upc <= '0;
        else
            upc <= upc_next;
    end

    // JZ always addresses location zero regardless of state
    a_jz_zero: assert property (@(posedge clk) disable iff (reset)
        (op == JZ) |-> (y == '0));

endmodule

/* tb/seq_model.svh */
`ifndef SEQ_MODEL_SVH
`define SEQ_MODEL_SVH

// model copy of the sequencer state
addr_t       m_upc;
addr_t       m_count;
addr_t       m_stack [1:STACK_DEPTH];
int          m_sp;                        // 0 means empty
logic [15:0] lfsr_state = 16'd15243;

// 16-bit fibonacci lfsr with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};   // newest bit in the lsb
    end
    return v;
endfunction

task automatic model_reset();
    m_upc   = '0;
    m_count = '0;
    m_sp    = 0;
    for (int i = 1; i <= STACK_DEPTH; i++)
        m_stack[i] = '0;
endtask

// cc packs cc_n above ccen_n so only 2'b10 fails
task automatic add_row(input int test, input seq_op_e op, input logic [1:0] cc,
                       input int dval, input int ci = 1, input int rld = 1);
    row_t r;
    r        = '0;
    r.test   = 4'(test);
    r.op     = op;
    r.cc_n   = cc[1];
    r.ccen_n = cc[0];
    r.rld_n  = rld[0];
    r.ci     = ci[0];
    r.d      = addr_t'(dval);
    rows.push_back(r);
endtask

// expected outputs for one row and the state after the edge
task automatic model_row(inout row_t r);
    logic  fail;
    logic  zero;
    logic  push;
    logic  pop;
    logic  clr;
    logic  ld;
    logic  dec;
    logic  pl;
    logic  map;
    logic  vect;
    addr_t top;
    addr_t y;
    fail = r.cc_n && !r.ccen_n;   // only fails when enabled and false
    zero = (m_count == '0);
    top  = (m_sp == 0) ? '0 : m_stack[m_sp];
    push = 1'b0;
    pop  = 1'b0;
    clr  = 1'b0;
    ld   = 1'b0;
    dec  = 1'b0;
    pl   = 1'b0;   // pipeline strobe on by default
    map  = 1'b1;
    vect = 1'b1;
    y    = m_upc;
    case (r.op)
        JZ: begin
            y   = '0;
            clr = 1'b1;
        end
        CJS: begin
            y    = fail ? m_upc : r.d;
            push = !fail;
        end
        JMAP: begin
            y   = r.d;
            pl  = 1'b1;
            map = 1'b0;   // map prom is the source
        end
        CJP: y = fail ? m_upc : r.d;
        CJV: begin
            y    = fail ? m_upc : r.d;
            pl   = 1'b1;
            vect = 1'b0;   // vector source
        end
        PUSH: begin
            push = 1'b1;
            ld   = !fail;
        end
        JSRP: begin
            y    = fail ? m_count : r.d;
            push = 1'b1;
        end
        JRP: y = fail ? m_count : r.d;
        RFCT: begin
            y   = zero ? m_upc : top;
            dec = !zero;
            pop = zero;
        end
        RPCT: begin
            y   = zero ? m_upc : r.d;
            dec = !zero;
        end
        CRTN, CJPP: begin
            y   = fail ? m_upc : ((r.op == CRTN) ? top : r.d);
            pop = !fail;
        end
        LDCT: ld = 1'b1;
        LOOP: begin
            y   = fail ? top : m_upc;
            pop = !fail;
        end
        CONT: y = m_upc;
        TWB: begin
            y   = !fail ? m_upc : (zero ? r.d : top);   // three exits
            pop = !fail || zero;
            dec = fail && !zero;
        end
    endcase
    r.exp_y      = y;
    r.exp_pl_n   = pl;
    r.exp_map_n  = map;
    r.exp_vect_n = vect;
    r.exp_full   = (m_sp == STACK_DEPTH);
    if (ld || !r.rld_n)
        m_count = r.d;
    else if (dec)
        m_count = m_count - 12'd1;
    if (clr)
        m_sp = 0;
    else if (pop) begin
        if (m_sp > 0)
            m_sp--;
    end else if (push) begin
        if (m_sp < STACK_DEPTH)
            m_sp++;                    // full stack keeps the pointer
        m_stack[m_sp] = m_upc;         // return address is the old upc
    end
    m_upc = clr ? '0 : y + addr_t'(r.ci);
endtask

task automatic build_directed();
    seq_op_e br_ops [3];
    br_ops = '{CJP, CJV, JMAP};
    for (int i = 0; i < 5; i++)
        add_row(1, CONT, 2'b11, 0);          // y counts up from zero
    add_row(1, CONT, 2'b11, 0, 0);           // ci low holds the address
    add_row(1, CONT, 2'b11, 0, 0);
    add_row(1, JZ, 2'b11, 'h7ff);
    add_row(1, CONT, 2'b11, 0);
    for (int k = 0; k < 3; k++)
        for (int c = 0; c < 4; c++)
            add_row(2, br_ops[k], 2'(c), 'h200 + 16 * k + c);
    add_row(3, JZ, 2'b11, 0);
    for (int i = 0; i < 6; i++) begin
        add_row(3, CJS, 2'b11, 'h300 + 8 * i);   // sixth call lands on a full stack
        add_row(3, CJS, 2'b10, 'h3f0);
    end
    for (int i = 0; i < 7; i++)
        add_row(3, CRTN, 2'b11, 0);              // last return reads entry zero
    add_row(3, CRTN, 2'b10, 0);
    add_row(4, LDCT, 2'b11, 3);
    for (int i = 0; i < 5; i++)
        add_row(4, RPCT, 2'b11, 'h400);
    add_row(4, CONT, 2'b11, 2, 1, 0);            // rld_n low loads 2
    add_row(4, PUSH, 2'b10, 'h444);              // loop start without a load on fail
    for (int i = 0; i < 4; i++)
        add_row(4, RFCT, 2'b11, 0);
    add_row(4, CONT, 2'b11, 1, 1, 0);
    add_row(4, PUSH, 2'b10, 0);
    add_row(4, TWB, 2'b10, 'h480);               // nonzero count goes back to the stack
    add_row(4, TWB, 2'b10, 'h480);               // count ran out so d is taken
    add_row(4, PUSH, 2'b11, 5);
    add_row(4, TWB, 2'b11, 'h490);               // condition met
    add_row(5, JZ, 2'b11, 0);
    add_row(5, LDCT, 2'b11, 'h050);
    add_row(5, JSRP, 2'b11, 'h500);
    add_row(5, JSRP, 2'b10, 'h510);
    add_row(5, JRP, 2'b11, 'h520);
    add_row(5, JRP, 2'b10, 'h530);
    add_row(5, CJPP, 2'b11, 'h540);
    add_row(5, CJPP, 2'b10, 'h550);
    add_row(5, PUSH, 2'b11, 'h007);
    add_row(5, PUSH, 2'b10, 'h008);
    add_row(5, LOOP, 2'b10, 0);
    add_row(5, LOOP, 2'b11, 0);
    add_row(5, LOOP, 2'b00, 0);                  // enabled and true
endtask

task automatic build_random(input int n);
    logic [3:0] code;
    logic [1:0] cc;
    int         dval;
    int         cin;
    int         rld;
    for (int i = 0; i < n; i++) begin
        code = 4'(rand_bits(4));
        cc   = 2'(rand_bits(2));
        dval = int'(rand_bits(12));
        cin  = int'(rand_bits(1));
        rld  = (rand_bits(3) == 32'd0) ? 0 : 1;   // forced load now and then
        add_row(6, seq_op_e'(code), cc, dval, cin, rld);
    end
endtask

`endif

/* tb/tb_seq_top.sv */
module tb_seq_top;
    timeunit 1ns;
    timeprecision 1ps;
    import seq_pkg::*;

    localparam real CLK_PERIOD = 4.0;

    // one row of stimulus with its expected outputs
    typedef struct packed {
        logic [3:0] test;
        seq_op_e    op;
        logic       cc_n;
        logic       ccen_n;
        logic       rld_n;
        logic       ci;
        addr_t      d;
        addr_t      exp_y;
        logic       exp_pl_n;
        logic       exp_map_n;
        logic       exp_vect_n;
        logic       exp_full;
    } row_t;

    logic    clk;
    logic    reset;
    seq_op_e op;
    logic    cc_n;
    logic    ccen_n;
    logic    rld_n;
    logic    ci;
    addr_t   d;
    addr_t   y;
    logic    pl_n;
    logic    map_n;
    logic    vect_n;
    logic    full;

    row_t rows [$];
    logic table_ready = 1'b0;
    int   checks      = 0;
    int   errors      = 0;
    int   test_errs   = 0;   // errors in the test now running

    `include "seq_model.svh"

    seq_top DUT (
        .clk    (clk),
        .reset  (reset),
        .op     (op),
        .cc_n   (cc_n),
        .ccen_n (ccen_n),
        .rld_n  (rld_n),
        .ci     (ci),
        .d      (d),
        .y      (y),
        .pl_n   (pl_n),
        .map_n  (map_n),
        .vect_n (vect_n),
        .full   (full)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            test_errs++;
            $display("FAIL at %0.1f ns: %s got %0h expected %0h", $realtime, what, got,
                     expected);
        end
    endtask

    function automatic string test_title(input logic [3:0] t);
        case (t)
            4'd1:    return "upc count, hold and JZ";
            4'd2:    return "CJP, CJV, JMAP and strobes";
            4'd3:    return "subroutine stack";
            4'd4:    return "counter loops and TWB";
            4'd5:    return "PUSH, JSRP, JRP, CJPP, LOOP";
            default: return "random sequence";
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ends a run that stops making progress
    initial begin
        wait (table_ready);
        #(2.0 * rows.size() * CLK_PERIOD + 200.0);
        $display("timeout: the table was not finished in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        row_t r;
        int   test_rows;
        reset  <= 1'b1;
        op     <= CONT;   // idle: holds upc at zero
        cc_n   <= 1'b1;
        ccen_n <= 1'b1;
        rld_n  <= 1'b1;
        ci     <= 1'b0;
        d      <= '0;
        test_rows = 0;
        model_reset();
        build_directed();
        build_random(400);
        foreach (rows[i]) begin
            r = rows[i];
            model_row(r);
            rows[i] = r;
        end
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            op     <= rows[i].op;
            cc_n   <= rows[i].cc_n;
            ccen_n <= rows[i].ccen_n;
            rld_n  <= rows[i].rld_n;
            ci     <= rows[i].ci;
            d      <= rows[i].d;
            #(CLK_PERIOD - 0.5);   // outputs settled, next edge not yet here
            check_value($sformatf("row %0d y", i), 32'(y), 32'(rows[i].exp_y));
            check_value($sformatf("row %0d pl_n", i), 32'(pl_n), 32'(rows[i].exp_pl_n));
            check_value($sformatf("row %0d map_n", i), 32'(map_n), 32'(rows[i].exp_map_n));
            check_value($sformatf("row %0d vect_n", i), 32'(vect_n),
                        32'(rows[i].exp_vect_n));
            check_value($sformatf("row %0d full", i), 32'(full), 32'(rows[i].exp_full));
            test_rows++;
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                $display("test %0d %s: %0d rows, %0d errors", rows[i].test,
                         test_title(rows[i].test), test_rows, test_errs);
                test_rows = 0;
                test_errs = 0;
            end
        end

        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
